//--- tftPkg.sv
// shared types and constants for the ILI9341 8080-I parallel display controller
`default_nettype none

package tftPkg;

    // one byte on the panel bus, msb is the data/command flag (1 = data)
    typedef logic [8:0] busWord;

    // what an init ROM word means
    typedef enum logic [1:0]
    {
        byteEntry,
        delayEntry,
        endEntry
    } entryKind;

    // byte view: flag and byte go straight out on the bus
    typedef struct packed
    {
        entryKind   kind;
        logic       isData;
        logic [7:0] value;
    } entryByteView;

    // delay view: wait this many milliseconds before the next entry
    typedef struct packed
    {
        entryKind   kind;
        logic [8:0] ms;
    } entryDelayView;

    // kind sits in the same two top bits of both views
    typedef union packed
    {
        entryByteView  asByte;
        entryDelayView asDelay;
    } initEntry;

    // window commands sent at the start of each frame
    localparam logic [7:0] cmdColumnSet   = 8'h2A;
    localparam logic [7:0] cmdPageSet     = 8'h2B;
    localparam logic [7:0] cmdMemoryWrite = 8'h2C;

    localparam int initRomDepth = 16;

endpackage

`default_nettype wire

//--- initRom.sv
// init ROM holding the ILI9341 power-up program as byte, delay and end entries
`timescale 1ns/1ps
`default_nettype none

module initRom
(
    input  wire logic [$clog2(tftPkg::initRomDepth)-1:0] index,
    output tftPkg::initEntry                             entry
);

    always_comb
    begin
        // unused slots read back as end markers
        entry = '0;
        entry.asByte.kind = tftPkg::endEntry;
        case (index)
            // software reset, panel needs 5 ms afterwards
            4'd0: entry.asByte = '{tftPkg::byteEntry, 1'b0, 8'h01};
            4'd1: entry.asDelay = '{tftPkg::delayEntry, 9'd5};
            // sleep out, 120 ms before any further command
            4'd2: entry.asByte = '{tftPkg::byteEntry, 1'b0, 8'h11};
            4'd3: entry.asDelay = '{tftPkg::delayEntry, 9'd120};
            // pixel format 16 bit per pixel
            4'd4: entry.asByte = '{tftPkg::byteEntry, 1'b0, 8'h3A};
            4'd5: entry.asByte = '{tftPkg::byteEntry, 1'b1, 8'h55};
            // memory access control, bgr order and column mirror
            4'd6: entry.asByte = '{tftPkg::byteEntry, 1'b0, 8'h36};
            4'd7: entry.asByte = '{tftPkg::byteEntry, 1'b1, 8'h48};
            // display on
            4'd8: entry.asByte = '{tftPkg::byteEntry, 1'b0, 8'h29};
            4'd9: entry.asDelay = '{tftPkg::delayEntry, 9'd10};
            4'd10: entry.asByte = '{tftPkg::endEntry, 1'b0, 8'h00};
            default:
            begin
                entry.asByte = '{tftPkg::endEntry, 1'b0, 8'h00};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- initSequencer.sv
// init sequencer: panel reset hold, ROM walk with ms delays, then init-done flag
`timescale 1ns/1ps
`default_nettype none

module initSequencer
#(
    parameter int msTicks    = 50000,
    parameter int resetTicks = 500000
)
(
    input  wire logic           clk,
    input  wire logic           reset,
    output logic                seqCyc,
    output logic                seqStb,
    output tftPkg::busWord      seqDat,
    input  wire logic           seqAck,
    output logic                initDone,
    output logic                tftReset
);

    // counter must hold the reset hold time or the largest ms count
    localparam int countWidth = $clog2(resetTicks + 512);
    localparam int prescaleWidth = $clog2(msTicks + 1);
    localparam int indexWidth = $clog2(tftPkg::initRomDepth);

    typedef enum logic [2:0]
    {
        resetHold,
        fetch,
        send,
        delay,
        done
    } seqState;

    seqState                  state;
    logic [indexWidth-1:0]    romIndex;
    logic [countWidth-1:0]    delayCount;
    logic [prescaleWidth-1:0] prescale;
    tftPkg::initEntry         romEntry;

    initRom u_initRom
    (
        .index (romIndex),
        .entry (romEntry)
    );

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= resetHold;
            romIndex   <= '0;
            delayCount <= countWidth'(resetTicks - 1);
            prescale   <= '0;
            seqCyc     <= 1'b0;
            seqStb     <= 1'b0;
            initDone   <= 1'b0;
            tftReset   <= 1'b0;
        end
        else
        begin
            case (state)
                // panel reset counts raw clock cycles, no prescale
                resetHold:
                begin
                    if (delayCount == '0)
                    begin
                        tftReset <= 1'b1;
                        state    <= fetch;
                    end
                    else
                    begin
                        delayCount <= delayCount - 1'b1;
                    end
                end
                fetch:
                begin
                    case (romEntry.asByte.kind)
                        tftPkg::byteEntry:
                        begin
                            seqCyc <= 1'b1;
                            seqStb <= 1'b1;
                            state  <= send;
                        end
                        tftPkg::delayEntry:
                        begin
                            delayCount <= countWidth'(romEntry.asDelay.ms - 9'd1);
                            prescale   <= '0;
                            state      <= delay;
                        end
                        default:
                        begin
                            initDone <= 1'b1;
                            state    <= done;
                        end
                    endcase
                end
                // hold the word until the writer acks it
                send:
                begin
                    if (seqAck)
                    begin
                        seqCyc   <= 1'b0;
                        seqStb   <= 1'b0;
                        romIndex <= romIndex + 1'b1;
                        state    <= fetch;
                    end
                end
                // count one ms per prescale wrap
                delay:
                begin
                    if (prescale == prescaleWidth'(msTicks - 1))
                    begin
                        prescale <= '0;
                        if (delayCount == '0)
                        begin
                            romIndex <= romIndex + 1'b1;
                            state    <= fetch;
                        end
                        else
                        begin
                            delayCount <= delayCount - 1'b1;
                        end
                    end
                    else
                    begin
                        prescale <= prescale + 1'b1;
                    end
                end
                default:
                begin
                    state <= done;
                end
            endcase
        end
    end

    // bus word is picked up from the byte view when a send starts
    always_ff @(posedge clk)
    begin
        if (state == fetch)
        begin
            seqDat <= {romEntry.asByte.isData, romEntry.asByte.value};
        end
    end

endmodule

`default_nettype wire

//--- frameStreamer.sv
// frame streamer: window commands per frame, then RGB565 pixels from the source
`timescale 1ns/1ps
`default_nettype none

module frameStreamer
#(
    parameter int frameWidth  = 240,
    parameter int frameHeight = 320
)
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        initDone,
    output logic             strCyc,
    output logic             strStb,
    output tftPkg::busWord   strDat,
    input  wire logic        strAck,
    input  wire logic [15:0] pixelData,
    input  wire logic        pixelValid,
    output logic             pixelReady
);

    localparam int pixelTotal = frameWidth * frameHeight;
    localparam int pixelWidth = $clog2(pixelTotal + 1);
    localparam logic [15:0] lastColumn = 16'(frameWidth - 1);
    localparam logic [15:0] lastPage = 16'(frameHeight - 1);
    localparam logic [3:0] windowLast = 4'd10;

    typedef enum logic [1:0]
    {
        frameStart,
        window,
        pixels
    } strState;

    strState               state;
    logic [3:0]            phase;
    logic [pixelWidth-1:0] pixelCount;
    logic                  lowHalf;

    // eleven window bytes, start coordinates are always zero
    function automatic tftPkg::busWord windowByte(input logic [3:0] step);
        case (step)
            4'd0: return {1'b0, tftPkg::cmdColumnSet};
            4'd3: return {1'b1, lastColumn[15:8]};
            4'd4: return {1'b1, lastColumn[7:0]};
            4'd5: return {1'b0, tftPkg::cmdPageSet};
            4'd8: return {1'b1, lastPage[15:8]};
            4'd9: return {1'b1, lastPage[7:0]};
            4'd10: return {1'b0, tftPkg::cmdMemoryWrite};
            default: return {1'b1, 8'h00};
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= frameStart;
            phase      <= '0;
            pixelCount <= '0;
            lowHalf    <= 1'b0;
            strCyc     <= 1'b0;
            strStb     <= 1'b0;
            pixelReady <= 1'b0;
        end
        else
        begin
            pixelReady <= 1'b0;
            case (state)
                // wait for the panel to finish init, then open the window
                frameStart:
                begin
                    if (initDone)
                    begin
                        phase  <= '0;
                        strDat <= windowByte(4'd0);
                        strCyc <= 1'b1;
                        strStb <= 1'b1;
                        state  <= window;
                    end
                end
                window:
                begin
                    if (strAck)
                    begin
                        if (phase == windowLast)
                        begin
                            strCyc     <= 1'b0;
                            strStb     <= 1'b0;
                            pixelCount <= '0;
                            state      <= pixels;
                        end
                        else
                        begin
                            phase  <= phase + 1'b1;
                            strDat <= windowByte(phase + 1'b1);
                        end
                    end
                end
                default:
                begin
                    // pixelReady high means the source is still swapping in the next pixel
                    if (!strCyc && pixelValid && !pixelReady)
                    begin
                        strDat  <= {1'b1, pixelData[15:8]};
                        lowHalf <= 1'b0;
                        strCyc  <= 1'b1;
                        strStb  <= 1'b1;
                    end
                    else if (strAck && !lowHalf)
                    begin
                        strDat  <= {1'b1, pixelData[7:0]};
                        lowHalf <= 1'b1;
                    end
                    else if (strAck)
                    begin
                        // low byte done, pixel consumed
                        strCyc     <= 1'b0;
                        strStb     <= 1'b0;
                        pixelReady <= 1'b1;
                        pixelCount <= pixelCount + 1'b1;
                        if (pixelCount == pixelWidth'(pixelTotal - 1))
                        begin
                            state <= frameStart;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- busArbiter.sv
// bus arbiter: fixed priority between init sequencer and frame streamer
`timescale 1ns/1ps
`default_nettype none

module busArbiter
(
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           seqCyc,
    input  wire logic           seqStb,
    input  wire tftPkg::busWord seqDat,
    output logic                seqAck,
    input  wire logic           strCyc,
    input  wire logic           strStb,
    input  wire tftPkg::busWord strDat,
    output logic                strAck,
    output logic                busCyc,
    output logic                busStb,
    output tftPkg::busWord      busDat,
    input  wire logic           busAck
);

    // 0 = sequencer owns the writer, 1 = streamer
    logic strOwner;
    logic ownerCyc;

    assign ownerCyc = strOwner ? strCyc : seqCyc;

    // grant may only move while the current owner is idle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            strOwner <= 1'b0;
        end
        else if (!ownerCyc)
        begin
            if (seqCyc)
            begin
                strOwner <= 1'b0;
            end
            else if (strCyc)
            begin
                strOwner <= 1'b1;
            end
        end
    end

    // request mux toward the writer
    assign busCyc = ownerCyc;
    assign busStb = strOwner ? strStb : seqStb;
    assign busDat = strOwner ? strDat : seqDat;

    // ack only reaches the owner
    assign seqAck = busAck & ~strOwner;
    assign strAck = busAck & strOwner;

endmodule

`default_nettype wire

//--- parallelWriter.sv
// parallel writer: one bus word becomes one timed 8080-I write strobe
`timescale 1ns/1ps
`default_nettype none

module parallelWriter
#(
    parameter int wrLowTicks  = 2,
    parameter int wrHighTicks = 2
)
(
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           busCyc,
    input  wire logic           busStb,
    input  wire tftPkg::busWord busDat,
    output logic                busAck,
    output logic [7:0]          tftData,
    output logic                tftDataCmd,
    output logic                tftChipSelect,
    output logic                tftWrite
);

    localparam int tickWidth = $clog2((wrLowTicks > wrHighTicks ? wrLowTicks : wrHighTicks) + 1);

    typedef enum logic [1:0]
    {
        idle,
        strobeLow,
        strobeHigh
    } wrPhase;

    wrPhase               phase;
    logic [tickWidth-1:0] tickCount;

    // ack in the last cycle of the high phase
    assign busAck = (phase == strobeHigh) && (tickCount == tickWidth'(wrHighTicks - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase         <= idle;
            tickCount     <= '0;
            tftChipSelect <= 1'b1;
            tftWrite      <= 1'b1;
        end
        else
        begin
            case (phase)
                idle:
                begin
                    if (busCyc && busStb)
                    begin
                        tftChipSelect <= 1'b0;
                        tftWrite      <= 1'b0;
                        tickCount     <= '0;
                        phase         <= strobeLow;
                    end
                    else if (!busCyc)
                    begin
                        tftChipSelect <= 1'b1;
                    end
                end
                // panel samples on the rising edge at the end of this phase
                strobeLow:
                begin
                    if (tickCount == tickWidth'(wrLowTicks - 1))
                    begin
                        tftWrite  <= 1'b1;
                        tickCount <= '0;
                        phase     <= strobeHigh;
                    end
                    else
                    begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
                default:
                begin
                    if (busAck)
                    begin
                        phase <= idle;
                    end
                    else
                    begin
                        tickCount <= tickCount + 1'b1;
                    end
                end
            endcase
        end
    end

    // byte and flag latched as the strobe falls, stable through the low phase
    always_ff @(posedge clk)
    begin
        if ((phase == idle) && busCyc && busStb)
        begin
            tftDataCmd <= busDat[8];
            tftData    <= busDat[7:0];
        end
    end

endmodule

`default_nettype wire

//--- tftCtrlTop.sv
// top level of the ILI9341 controller, sets timing and frame parameters
`timescale 1ns/1ps
`default_nettype none

module tftCtrlTop
#(
    parameter int frameWidth  = 240,
    parameter int frameHeight = 320,
    parameter int msTicks     = 50000,
    // 10 ms of panel reset at 50 MHz
    parameter int resetTicks  = 500000,
    parameter int wrLowTicks  = 2,
    parameter int wrHighTicks = 2
)
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [15:0] pixelData,
    input  wire logic        pixelValid,
    output logic             pixelReady,
    output logic [7:0]       tftData,
    output logic             tftDataCmd,
    output logic             tftChipSelect,
    output logic             tftWrite,
    output logic             tftReset
);

    logic           seqCyc;
    logic           seqStb;
    tftPkg::busWord seqDat;
    logic           seqAck;
    logic           strCyc;
    logic           strStb;
    tftPkg::busWord strDat;
    logic           strAck;
    logic           busCyc;
    logic           busStb;
    tftPkg::busWord busDat;
    logic           busAck;
    logic           initDone;

    initSequencer #(.msTicks(msTicks), .resetTicks(resetTicks)) u_initSequencer
    (
        .clk      (clk),
        .reset    (reset),
        .seqCyc   (seqCyc),
        .seqStb   (seqStb),
        .seqDat   (seqDat),
        .seqAck   (seqAck),
        .initDone (initDone),
        .tftReset (tftReset)
    );

    frameStreamer #(.frameWidth(frameWidth), .frameHeight(frameHeight)) u_frameStreamer
    (
        .clk        (clk),
        .reset      (reset),
        .initDone   (initDone),
        .strCyc     (strCyc),
        .strStb     (strStb),
        .strDat     (strDat),
        .strAck     (strAck),
        .pixelData  (pixelData),
        .pixelValid (pixelValid),
        .pixelReady (pixelReady)
    );

    // sequencer wins when both ask, though in practice they never overlap
    busArbiter u_busArbiter
    (
        .clk    (clk),
        .reset  (reset),
        .seqCyc (seqCyc),
        .seqStb (seqStb),
        .seqDat (seqDat),
        .seqAck (seqAck),
        .strCyc (strCyc),
        .strStb (strStb),
        .strDat (strDat),
        .strAck (strAck),
        .busCyc (busCyc),
        .busStb (busStb),
        .busDat (busDat),
        .busAck (busAck)
    );

    parallelWriter #(.wrLowTicks(wrLowTicks), .wrHighTicks(wrHighTicks)) u_parallelWriter
    (
        .clk           (clk),
        .reset         (reset),
        .busCyc        (busCyc),
        .busStb        (busStb),
        .busDat        (busDat),
        .busAck        (busAck),
        .tftData       (tftData),
        .tftDataCmd    (tftDataCmd),
        .tftChipSelect (tftChipSelect),
        .tftWrite      (tftWrite)
    );

endmodule

`default_nettype wire

//--- tbPanelMonitor.sv
// panel model for the testbench, captures each byte and flag as the write strobe rises
`timescale 1ns/1ps
`default_nettype none

module tbPanelMonitor
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] tftData,
    input  wire logic       tftDataCmd,
    input  wire logic       tftChipSelect,
    input  wire logic       tftWrite,
    output logic            capValid,
    output logic [7:0]      capByte,
    output logic            capIsData,
    output int              capLowCycles,
    output logic            capStable
);

    logic       prevWrite;
    logic [8:0] lowWord;
    int         lowCount;
    logic       lowStable;

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prevWrite    <= 1'b1;
            lowWord      <= '0;
            lowCount     <= 0;
            lowStable    <= 1'b1;
            capValid     <= 1'b0;
            capByte      <= '0;
            capIsData    <= 1'b0;
            capLowCycles <= 0;
            capStable    <= 1'b1;
        end
        else
        begin
            prevWrite <= tftWrite;
            capValid  <= 1'b0;
            if (!tftWrite)
            begin
                // first low sample opens a new strobe
                if (prevWrite)
                begin
                    lowCount  <= 1;
                    lowStable <= 1'b1;
                    lowWord   <= {tftDataCmd, tftData};
                end
                else
                begin
                    lowCount <= lowCount + 1;
                    // byte or flag moving under a low strobe
                    if ({tftDataCmd, tftData} != lowWord)
                    begin
                        lowStable <= 1'b0;
                    end
                end
            end
            else if (!prevWrite && !tftChipSelect)
            begin
                // rising edge of the strobe, the panel latches here
                capValid     <= 1'b1;
                capByte      <= tftData;
                capIsData    <= tftDataCmd;
                capLowCycles <= lowCount;
                capStable    <= lowStable;
            end
        end
    end

endmodule

`default_nettype wire

//--- tbTftCtrl.sv
// testbench for the ILI9341 controller, checks init program, window bytes and pixels
`timescale 1ns/1ps
`default_nettype none

module tbTftCtrl;

    // small frame and fast timing so a full run stays short
    localparam int frameWidth     = 4;
    localparam int frameHeight    = 3;
    localparam int msTicks        = 5;
    localparam int resetTicks     = 10;
    localparam int wrLowTicks     = 2;
    localparam int wrHighTicks    = 2;
    localparam logic [15:0] pixelBase = 16'hA53C;
    localparam int captureTimeout = 2000;
    localparam int resetTimeout   = resetTicks + 20;

    logic        clk;
    logic        reset;
    logic [15:0] pixelData;
    logic        pixelValid;
    logic        pixelReady;
    logic [7:0]  tftData;
    logic        tftDataCmd;
    logic        tftChipSelect;
    logic        tftWrite;
    logic        tftReset;

    logic        capValid;
    logic [7:0]  capByte;
    logic        capIsData;
    int          capLowCycles;
    logic        capStable;

    integer      seed;
    int          cycleCount;
    int          lastCapture;
    int          waited;
    logic [15:0] expectedPixel;

    tftCtrlTop
    #(
        .frameWidth  (frameWidth),
        .frameHeight (frameHeight),
        .msTicks     (msTicks),
        .resetTicks  (resetTicks),
        .wrLowTicks  (wrLowTicks),
        .wrHighTicks (wrHighTicks)
    )
    u_dut
    (
        .clk           (clk),
        .reset         (reset),
        .pixelData     (pixelData),
        .pixelValid    (pixelValid),
        .pixelReady    (pixelReady),
        .tftData       (tftData),
        .tftDataCmd    (tftDataCmd),
        .tftChipSelect (tftChipSelect),
        .tftWrite      (tftWrite),
        .tftReset      (tftReset)
    );

    tbPanelMonitor u_monitor
    (
        .clk           (clk),
        .reset         (reset),
        .tftData       (tftData),
        .tftDataCmd    (tftDataCmd),
        .tftChipSelect (tftChipSelect),
        .tftWrite      (tftWrite),
        .capValid      (capValid),
        .capByte       (capByte),
        .capIsData     (capIsData),
        .capLowCycles  (capLowCycles),
        .capStable     (capStable)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cycle stamp used to measure gaps between panel writes
    always @(posedge clk)
    begin
        if (reset)
        begin
            cycleCount <= 0;
        end
        else
        begin
            cycleCount <= cycleCount + 1;
        end
    end

    // pixel source, valid stays up until the pixel is taken, then may drop at random
    always @(posedge clk)
    begin
        if (reset)
        begin
            pixelValid <= 1'b0;
        end
        else if (pixelReady)
        begin
            pixelData  <= pixelData + 16'd1;
            pixelValid <= ($random(seed) & 3) != 0;
        end
        else if (!pixelValid)
        begin
            pixelValid <= ($random(seed) & 3) != 0;
        end
    end

    task automatic stopRun();
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic reportValue(input string name, input int expected, input int actual);
        $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected,
                 actual);
        stopRun();
    endtask

    task automatic reportProblem(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        stopRun();
    endtask

    // wait for the next captured byte and compare it, minGap is in clock cycles
    task automatic expectWrite(input logic isData, input logic [7:0] value, input int minGap);
        int count;
        int gap;
        @(posedge clk);
        count = 1;
        while (!capValid && count < captureTimeout)
        begin
            @(posedge clk);
            count++;
        end
        if (!capValid)
        begin
            reportProblem("no write strobe reached the panel within the timeout");
        end
        else
        begin
            gap = cycleCount - lastCapture;
            lastCapture = cycleCount;
            assert (capByte == value)
                else reportValue("tftData", int'(value), int'(capByte));
            assert (capIsData == isData)
                else reportValue("tftDataCmd", int'(isData), int'(capIsData));
            assert (capLowCycles >= wrLowTicks)
                else reportValue("tftWrite low cycles (minimum)", wrLowTicks, capLowCycles);
            assert (capStable)
                else reportProblem("tftData changed while tftWrite was low");
            assert (gap >= minGap)
                else reportValue("cycles since previous write (minimum)", minGap, gap);
        end
    endtask

    // window commands, then every pixel high byte first
    task automatic expectFrame(input int firstGap);
        int p;
        expectWrite(1'b0, tftPkg::cmdColumnSet, firstGap);
        expectWrite(1'b1, 8'h00, 0);
        expectWrite(1'b1, 8'h00, 0);
        expectWrite(1'b1, 8'((frameWidth - 1) >> 8), 0);
        expectWrite(1'b1, 8'(frameWidth - 1), 0);
        expectWrite(1'b0, tftPkg::cmdPageSet, 0);
        expectWrite(1'b1, 8'h00, 0);
        expectWrite(1'b1, 8'h00, 0);
        expectWrite(1'b1, 8'((frameHeight - 1) >> 8), 0);
        expectWrite(1'b1, 8'(frameHeight - 1), 0);
        expectWrite(1'b0, tftPkg::cmdMemoryWrite, 0);
        for (p = 0; p < frameWidth * frameHeight; p++)
        begin
            expectWrite(1'b1, expectedPixel[15:8], 0);
            expectWrite(1'b1, expectedPixel[7:0], 0);
            expectedPixel = expectedPixel + 16'd1;
        end
    endtask

    initial
    begin
        seed          = 38;
        reset         = 1'b1;
        pixelData     = pixelBase;
        pixelValid    = 1'b0;
        expectedPixel = pixelBase;
        lastCapture   = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // idle bus, no pixel taken yet and panel held in reset
        assert (tftChipSelect == 1'b1)
            else reportValue("tftChipSelect", 1, int'(tftChipSelect));
        assert (tftWrite == 1'b1)
            else reportValue("tftWrite", 1, int'(tftWrite));
        assert (tftReset == 1'b0)
            else reportValue("tftReset", 0, int'(tftReset));
        assert (pixelReady == 1'b0)
            else reportValue("pixelReady", 0, int'(pixelReady));

        // no strobe may come before the panel leaves reset
        waited = 0;
        while (!tftReset && waited < resetTimeout)
        begin
            assert (tftWrite)
                else reportProblem("write strobe while the panel was still in reset");
            @(posedge clk);
            waited++;
        end
        if (!tftReset)
        begin
            reportProblem("tftReset never went high");
        end

        // power-up program, delays show up as gaps only
        expectWrite(1'b0, 8'h01, 0);
        expectWrite(1'b0, 8'h11, 5 * msTicks);
        expectWrite(1'b0, 8'h3A, 120 * msTicks);
        expectWrite(1'b1, 8'h55, 0);
        expectWrite(1'b0, 8'h36, 0);
        expectWrite(1'b1, 8'h48, 0);
        expectWrite(1'b0, 8'h29, 0);

        // two frames, the second must repeat the window
        expectFrame(10 * msTicks);
        expectFrame(0);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
tftPkg.sv
initRom.sv
initSequencer.sv
frameStreamer.sv
busArbiter.sv
parallelWriter.sv
tftCtrlTop.sv
tbPanelMonitor.sv
tbTftCtrl.sv

//--- run.sh
#!/bin/sh
# build the ILI9341 controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbTftCtrl -f build.f -o simTftCtrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simTftCtrl 2>&1)
runStatus=$?
printf '%s\n' "$output"

if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
